/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - files:
      - hw/mipsPkg.sv
      - hw/instrDecoder.sv
      - hw/regFile.sv
      - hw/executeUnit.sv
      - hw/branchUnit.sv
      - hw/loadStoreUnit.sv
      - hw/mipsPipeline.sv
  - target: test
    files:
      - tests/mipsPipelineTb.sv

/* hw/branchUnit.sv */
`timescale 1ns/10ps

module branchUnit import mipsPkg::*; (
  input execReg_t exec,
  input logic [DATA_W-1:0] rsValue,
  input logic [DATA_W-1:0] rtValue,
  input logic [DATA_W-1:0] pc,
  output logic [DATA_W-1:0] nextPc,
  output logic [REG_AW-1:0] writeReg
);

  logic [DATA_W-1:0] seqPc;
  logic [DATA_W-1:0] slotPc;
  logic [DATA_W-1:0] branchTarget;
  logic [DATA_W-1:0] jumpTarget;

  // pc is the delay slot sitting in D, so fall-through simply continues
  assign seqPc = pc + DATA_W'(4);
  assign slotPc = exec.pc + DATA_W'(4);
  assign branchTarget = slotPc + {{(DATA_W-18){exec.instr[15]}}, exec.instr[15:0], 2'b00};
  // J stays within the 256 MB region of the delay slot
  assign jumpTarget = {slotPc[31:28], exec.instr[25:0], 2'b00};

  always_comb begin
    case (exec.ctrl.branchKind)
      brBeq: nextPc = (rsValue == rtValue) ? branchTarget : seqPc;
      brBne: nextPc = (rsValue != rtValue) ? branchTarget : seqPc;
      brJump: nextPc = jumpTarget;
      brJumpReg: nextPc = rsValue;
      default: nextPc = seqPc;
    endcase
  end

  assign writeReg = exec.ctrl.regDst ? exec.instr[15:11] : exec.instr[20:16];

endmodule

/* hw/executeUnit.sv */
`timescale 1ns/10ps

module executeUnit import mipsPkg::*; (
  input execReg_t exec,
  input logic [DATA_W-1:0] rsData,
  input logic [DATA_W-1:0] rtData,
  input memReg_t fwd,
  output logic [DATA_W-1:0] aluOut,
  output logic [DATA_W-1:0] rsValue,
  output logic [DATA_W-1:0] rtValue
);

  logic [REG_AW-1:0] rs;
  logic [REG_AW-1:0] rt;
  logic fwdUsable;
  logic [DATA_W-1:0] imm;
  logic [DATA_W-1:0] opB;
  logic [4:0] shamt;

  assign rs = exec.instr[25:21];
  assign rt = exec.instr[20:16];

  // Only ALU results in M can be forwarded, load data arrives too late
  assign fwdUsable = fwd.regWrite && !fwd.memToReg && fwd.writeReg != '0;
  assign rsValue = (fwdUsable && fwd.writeReg == rs) ? fwd.aluOut : rsData;
  assign rtValue = (fwdUsable && fwd.writeReg == rt) ? fwd.aluOut : rtData;

  assign imm = exec.ctrl.zeroExt ? {16'b0, exec.instr[15:0]}
                                 : {{16{exec.instr[15]}}, exec.instr[15:0]};
  assign opB = exec.ctrl.aluSrcImm ? imm : rtValue;
  assign shamt = exec.ctrl.shiftImm ? exec.instr[10:6] : rsValue[4:0];

  always_comb begin
    case (exec.ctrl.aluOp)
      aluAdd: aluOut = rsValue + opB;
      aluSub: aluOut = rsValue - opB;
      aluAnd: aluOut = rsValue & opB;
      aluOr: aluOut = rsValue | opB;
      aluXor: aluOut = rsValue ^ opB;
      aluNor: aluOut = ~(rsValue | opB);
      aluSlt: aluOut = DATA_W'($signed(rsValue) < $signed(opB));
      aluSltu: aluOut = DATA_W'(rsValue < opB);
      // Shifts act on rt, which rides in on the second operand
      aluSll: aluOut = opB << shamt;
      aluSrl: aluOut = opB >> shamt;
      aluSra: aluOut = $signed(opB) >>> shamt;
      aluLui: aluOut = {opB[15:0], 16'b0};
      default: aluOut = '0;
    endcase
  end

endmodule

/* hw/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder import mipsPkg::*; (
  input logic [DATA_W-1:0] instr,
  output ctrl_t ctrl
);

  typedef enum logic [5:0] {
    opSpecial = 6'h00, opJ = 6'h02, opBeq = 6'h04, opBne = 6'h05,
    opAddiu = 6'h09, opSlti = 6'h0a, opAndi = 6'h0c, opOri = 6'h0d,
    opXori = 6'h0e, opLui = 6'h0f, opLb = 6'h20, opLh = 6'h21,
    opLw = 6'h23, opLbu = 6'h24, opLhu = 6'h25, opSb = 6'h28,
    opSh = 6'h29, opSw = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03, fnJr = 6'h08,
    fnAddu = 6'h21, fnSubu = 6'h23, fnAnd = 6'h24, fnOr = 6'h25,
    fnXor = 6'h26, fnNor = 6'h27, fnSlt = 6'h2a, fnSltu = 6'h2b
  } funct_e;

  opcode_e opcode;
  funct_e funct;
  memSize_e accessSize;

  assign opcode = opcode_e'(instr[31:26]);
  assign funct = funct_e'(instr[5:0]);
  // Bits 27:26 give 00 byte, 01 half, 11 word for both loads and stores
  assign accessSize = (instr[27:26] == 2'b11) ? memWord : memSize_e'(instr[27:26]);

  always_comb begin
    ctrl = '0;
    case (opcode)
      opSpecial: begin
        ctrl.regDst = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)
          fnSll: begin
            ctrl.aluOp = aluSll;
            ctrl.shiftImm = 1'b1;
          end
          fnSrl: begin
            ctrl.aluOp = aluSrl;
            ctrl.shiftImm = 1'b1;
          end
          fnSra: begin
            ctrl.aluOp = aluSra;
            ctrl.shiftImm = 1'b1;
          end
          fnAddu: ctrl.aluOp = aluAdd;
          fnSubu: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr: ctrl.aluOp = aluOr;
          fnXor: ctrl.aluOp = aluXor;
          fnNor: ctrl.aluOp = aluNor;
          fnSlt: ctrl.aluOp = aluSlt;
          fnSltu: ctrl.aluOp = aluSltu;
          fnJr: begin
            ctrl = '0;
            ctrl.branchKind = brJumpReg;
          end
          default: ctrl = '0;
        endcase
      end
      opJ: ctrl.branchKind = brJump;
      opBeq: ctrl.branchKind = brBeq;
      opBne: ctrl.branchKind = brBne;
      opAddiu, opSlti, opAndi, opOri, opXori, opLui: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.zeroExt = (opcode == opAndi) || (opcode == opOri) || (opcode == opXori);
        case (opcode)
          opSlti: ctrl.aluOp = aluSlt;
          opAndi: ctrl.aluOp = aluAnd;
          opOri: ctrl.aluOp = aluOr;
          opXori: ctrl.aluOp = aluXor;
          opLui: ctrl.aluOp = aluLui;
          default: ctrl.aluOp = aluAdd;
        endcase
      end
      opLb, opLh, opLw, opLbu, opLhu: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memSize = accessSize;
        ctrl.loadUnsigned = instr[28];
      end
      opSb, opSh, opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.memSize = accessSize;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

/* hw/loadStoreUnit.sv */
`timescale 1ns/10ps

module loadStoreUnit import mipsPkg::*; (
  input logic clk,
  input logic storeEn,
  input logic [DATA_W-1:0] addr,
  input logic [DATA_W-1:0] storeData,
  input memSize_e memSize,
  input memReg_t mem,
  input logic readEnable,
  output logic [DATA_W-1:0] result
);

  logic [DATA_W-1:0] dmem [2**DMEM_AW];
  logic [DMEM_AW-1:0] wordAddr;
  logic [3:0] lanes;
  logic [DATA_W-1:0] laneData;
  logic [DATA_W-1:0] readWord;
  logic [7:0] loadByte;
  logic [15:0] loadHalf;

  function automatic logic isAligned(logic [1:0] offset, memSize_e size);
    case (size)
      memHalf: return !offset[0];
      memWord: return offset == 2'b00;
      default: return 1'b1;
    endcase
  endfunction

  // Little-endian lanes, lane 0 is the lowest byte address
  assign wordAddr = addr[DMEM_AW+1:2];

  always_comb begin
    case (memSize)
      memByte: begin
        lanes = 4'b0001 << addr[1:0];
        laneData = {4{storeData[7:0]}};
      end
      memHalf: begin
        lanes = addr[1] ? 4'b1100 : 4'b0011;
        laneData = {2{storeData[15:0]}};
      end
      default: begin
        lanes = 4'b1111;
        laneData = storeData;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (storeEn) begin
      for (int i = 0; i < 4; i++) begin
        if (lanes[i]) dmem[wordAddr][8*i +: 8] <= laneData[8*i +: 8];
      end
    end
    // Read data is held while stalled so the load in M keeps its value
    if (readEnable) readWord <= dmem[wordAddr];
  end

  // M side picks out the addressed part of the registered word
  assign loadByte = readWord[8*mem.aluOut[1:0] +: 8];
  assign loadHalf = mem.aluOut[1] ? readWord[31:16] : readWord[15:0];

  always_comb begin
    if (!mem.memToReg) begin
      result = mem.aluOut;
    end else begin
      case (mem.memSize)
        memByte: result = mem.loadUnsigned ? {24'b0, loadByte} : {{24{loadByte[7]}}, loadByte};
        memHalf: result = mem.loadUnsigned ? {16'b0, loadHalf} : {{16{loadHalf[15]}}, loadHalf};
        default: result = readWord;
      endcase
    end
  end

  storeAligned: assert property (@(posedge clk) storeEn |-> isAligned(addr[1:0], memSize));
  loadAligned: assert property (@(posedge clk)
    mem.memToReg |-> isAligned(mem.aluOut[1:0], mem.memSize));

endmodule

/* hw/mipsPipeline.sv */
`timescale 1ns/10ps

module mipsPipeline import mipsPkg::*; (
  input logic clk,
  input logic rst,
  input logic stall,
  input logic imemWe,
  input logic [IMEM_AW-1:0] imemAddr,
  input logic [DATA_W-1:0] imemData,
  output logic wbValid,
  output logic [REG_AW-1:0] wbReg,
  output logic [DATA_W-1:0] wbData
);

  logic [DATA_W-1:0] imem [2**IMEM_AW];
  logic [DATA_W-1:0] pc;
  logic [DATA_W-1:0] nextPc;
  logic [DATA_W-1:0] fetchPc;
  logic [DATA_W-1:0] instrD;
  ctrl_t ctrlD;

  execReg_t execE;
  logic [DATA_W-1:0] rsDataE;
  logic [DATA_W-1:0] rtDataE;
  logic [DATA_W-1:0] rsValueE;
  logic [DATA_W-1:0] rtValueE;
  logic [DATA_W-1:0] aluOutE;
  logic [REG_AW-1:0] writeRegE;

  memReg_t memM;
  logic [DATA_W-1:0] resultM;

  // Holding the fetch address while stalled keeps the D word valid
  assign fetchPc = rst ? '0 : (stall ? pc : nextPc);

  always_ff @(posedge clk) begin
    if (imemWe) imem[imemAddr] <= imemData;
    instrD <= imem[fetchPc[IMEM_AW+1:2]];
  end

  instrDecoder decoder (.instr(instrD), .ctrl(ctrlD));

  regFile registers (
    .clk(clk), .rst(rst), .we(wbValid),
    .raddrA(execE.instr[25:21]), .raddrB(execE.instr[20:16]),
    .waddr(memM.writeReg), .wdata(resultM),
    .rdataA(rsDataE), .rdataB(rtDataE)
  );

  executeUnit execute (
    .exec(execE), .rsData(rsDataE), .rtData(rtDataE), .fwd(memM),
    .aluOut(aluOutE), .rsValue(rsValueE), .rtValue(rtValueE)
  );

  branchUnit branch (
    .exec(execE), .rsValue(rsValueE), .rtValue(rtValueE), .pc(pc),
    .nextPc(nextPc), .writeReg(writeRegE)
  );

  // Store lands in E, load data comes back registered in M
  loadStoreUnit lsu (
    .clk(clk), .storeEn(execE.ctrl.memWrite && !stall), .addr(aluOutE),
    .storeData(rtValueE), .memSize(execE.ctrl.memSize), .mem(memM),
    .readEnable(!stall), .result(resultM)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      execE <= '0;
      memM <= '0;
    end else if (!stall) begin
      pc <= nextPc;
      execE <= '{instr: instrD, pc: pc, ctrl: ctrlD};
      memM <= '{aluOut: aluOutE, storeData: rtValueE, writeReg: writeRegE,
                regWrite: execE.ctrl.regWrite, memToReg: execE.ctrl.memToReg,
                memSize: execE.ctrl.memSize, loadUnsigned: execE.ctrl.loadUnsigned};
    end
  end

  // Writeback trace doubles as the register file write enable
  assign wbValid = memM.regWrite && memM.writeReg != '0 && !stall;
  assign wbReg = memM.writeReg;
  assign wbData = resultM;

endmodule

/* hw/mipsPkg.sv */
package mipsPkg;

  localparam int DATA_W = 32;
  localparam int REG_AW = 5;
  localparam int IMEM_AW = 8;
  localparam int DMEM_AW = 8;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
  } aluOp_e;

  typedef enum logic [2:0] {
    brNone, brBeq, brBne, brJump, brJumpReg
  } branchKind_e;

  // Values line up with the low two opcode bits of byte and half accesses
  typedef enum logic [1:0] {
    memByte, memHalf, memWord
  } memSize_e;

  typedef struct packed {
    aluOp_e aluOp;
    branchKind_e branchKind;
    memSize_e memSize;
    logic regDst;
    logic aluSrcImm;
    logic shiftImm;
    logic zeroExt;
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic loadUnsigned;
  } ctrl_t;

  typedef struct packed {
    logic [DATA_W-1:0] instr;
    logic [DATA_W-1:0] pc;
    ctrl_t ctrl;
  } execReg_t;

  typedef struct packed {
    logic [DATA_W-1:0] aluOut;
    logic [DATA_W-1:0] storeData;
    logic [REG_AW-1:0] writeReg;
    logic regWrite;
    logic memToReg;
    memSize_e memSize;
    logic loadUnsigned;
  } memReg_t;

endpackage

/* hw/regFile.sv */
`timescale 1ns/10ps

module regFile import mipsPkg::*; (
  input logic clk,
  input logic rst,
  input logic we,
  input logic [REG_AW-1:0] raddrA,
  input logic [REG_AW-1:0] raddrB,
  input logic [REG_AW-1:0] waddr,
  input logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdataA,
  output logic [DATA_W-1:0] rdataB
);

  logic [DATA_W-1:0] regs [2**REG_AW];

  // r0 stays zero because it is never written after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdataA = regs[raddrA];
  assign rdataB = regs[raddrB];

endmodule

/* tests/mipsPipelineTb.sv */
`timescale 1ns/10ps

module mipsPipelineTb import mipsPkg::*; ();

  logic clk = 1'b0;
  logic rst;
  logic stall;
  logic imemWe;
  logic [IMEM_AW-1:0] imemAddr;
  logic [DATA_W-1:0] imemData;
  logic wbValid;
  logic [REG_AW-1:0] wbReg;
  logic [DATA_W-1:0] wbData;

  // Flat image of the data file, programs and expected writebacks back to back
  logic [DATA_W-1:0] vec [256];
  integer seed = 53;
  int totalWords = 0;
  int expBase;
  int expCount;
  int seen;

  mipsPipeline uut (
    .clk(clk), .rst(rst), .stall(stall),
    .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  always #50 clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkReg(input string name, input logic [REG_AW-1:0] actual,
                          input logic [REG_AW-1:0] expected);
    if (actual !== expected) begin
      abortRun($sformatf("MISMATCH at %0t ns: %s = %0d, expected %0d",
                         $time, name, actual, expected));
    end
  endtask

  task automatic checkData(input string name, input logic [DATA_W-1:0] actual,
                           input logic [DATA_W-1:0] expected);
    if (actual !== expected) begin
      abortRun($sformatf("MISMATCH at %0t ns: %s = %h, expected %h",
                         $time, name, actual, expected));
    end
  endtask

  // Sample on the rising edge, then pick the next stall level on the falling edge
  task automatic stepCycle();
    @(posedge clk);
    if (wbValid) begin
      if (stall) abortRun("writeback reported while the pipeline was stalled");
      if (seen >= expCount) begin
        abortRun($sformatf("extra writeback to r%0d after the expected sequence", wbReg));
      end
      checkReg("wbReg", wbReg, vec[expBase + 2 * seen][REG_AW-1:0]);
      checkData("wbData", wbData, vec[expBase + 2 * seen + 1]);
      seen++;
    end
    @(negedge clk);
    stall = (($random(seed) & 3) == 0);
  endtask

  // Program goes in while stalled, then a reset restarts fetch at address 0
  task automatic loadProgram(input int base, input int count);
    stall = 1'b1;
    for (int i = 0; i < count; i++) begin
      imemWe = 1'b1;
      imemAddr = IMEM_AW'(i);
      imemData = vec[base + i];
      @(negedge clk);
    end
    imemWe = 1'b0;
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic runProgram(input int nWords);
    int cycles;
    cycles = 0;
    seen = 0;
    stall = 1'b0;
    while (seen < expCount) begin
      if (cycles > 8 * nWords + 40) begin
        abortRun($sformatf("missing writebacks, only %0d of %0d arrived", seen, expCount));
      end
      stepCycle();
      cycles++;
    end
    // Program now spins on its self-branch and must stay quiet
    repeat (20) stepCycle();
  endtask

  initial begin
    int ptr;
    int nWords;
    rst = 1'b1;
    stall = 1'b1;
    imemWe = 1'b0;
    imemAddr = '0;
    imemData = '0;
    for (int i = 0; i < 256; i++) begin
      vec[i] = '0;
    end
    $readmemh("tests/mipsPipelineTests.txt", vec);
    ptr = 0;
    while (ptr < 256 && vec[ptr] != '0) begin
      totalWords += vec[ptr][31:16];
      ptr += 1 + vec[ptr][31:16] + 2 * vec[ptr][15:0];
    end
    if (totalWords == 0) abortRun("no test programs found in the data file");
    repeat (4) @(negedge clk);
    rst = 1'b0;
    ptr = 0;
    while (ptr < 256 && vec[ptr] != '0) begin
      nWords = vec[ptr][31:16];
      expCount = vec[ptr][15:0];
      expBase = ptr + 1 + nWords;
      loadProgram(ptr + 1, nWords);
      runProgram(nWords);
      ptr = expBase + 2 * expCount;
    end
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    wait (totalWords > 0);
    repeat (40 * totalWords + 200) @(posedge clk);
    abortRun("watchdog expired before all programs finished");
  end

endmodule

/* tests/mipsPipelineTests.txt */
// Per program: header {word count, writeback count}, then the program words,
// then one (register, value) pair per expected writeback; a zero header ends the list
// ALU ops, shifts, LUI, forwarding and r0
0011000e
24010005 2422fffd 00411823 3c048001 3484f0f0 00042903
00043202 000138c0 0061402a 0061482b 00865024 00225827
396cffff 24200007 280d0001 1000ffff 00000000
00000001 00000005  00000002 00000002  00000003 fffffffd
00000004 80010000  00000004 8001f0f0  00000005 f8001f0f
00000006 008001f0  00000007 00000028  00000008 00000001
00000009 00000000  0000000a 000000f0  0000000b fffffff8
0000000c ffff0007  0000000d 00000001
// Word, half and byte stores, signed and unsigned loads
0011000c
3c011234 34215678 24020040 ac410000 2403ffff a0430001
24047e80 a4440002 8c450000 80460001 90470001 84480002
94490000 844a0000 804b0003 1000ffff 00000000
00000001 12340000  00000001 12345678  00000002 00000040
00000003 ffffffff  00000004 00007e80  00000005 7e80ff78
00000006 ffffffff  00000007 000000ff  00000008 00007e80
00000009 0000ff78  0000000a ffffff78  0000000b 0000007e
// BEQ and BNE taken and untaken, J and JR, each with one delay slot
00160009
24010001 24020002 10220002 24030003 14220002 24040004
24050005 0800000a 24060006 24070007 2408003c 01000008
24090009 240a000a 240b000b 14210005 240c000c 10420002
240d000d 240e000e 1000ffff 00000000
00000001 00000001  00000002 00000002  00000003 00000003
00000004 00000004  00000006 00000006  00000008 0000003c
00000009 00000009  0000000c 0000000c  0000000d 0000000d
00000000

/* verilog.f */
hw/mipsPkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/executeUnit.sv
hw/branchUnit.sv
hw/loadStoreUnit.sv
hw/mipsPipeline.sv
tests/mipsPipelineTb.sv
